/* filelist.f */
verilog/axi_pkg.sv
verilog/soc_map_pkg.sv
verilog/read_arbiter.sv
verilog/store_channel.sv
verilog/clint_timer.sv
verilog/bus_bridge.sv
tb/axi_mem_model.sv
tb/tb_bus_bridge.sv

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  wire         clock,
  input  wire         reset,
  input  wire  [31:0] axi_araddr,
  input  wire         axi_arvalid,
  output logic        axi_arready,
  output logic [31:0] axi_rdata,
  output logic        axi_rvalid,
  output logic        axi_rlast,
  output logic [3:0]  axi_rid,
  output logic [1:0]  axi_rresp,
  input  wire         axi_rready,
  input  wire  [31:0] axi_awaddr,
  input  wire         axi_awvalid,
  output logic        axi_awready,
  input  wire  [31:0] axi_wdata,
  input  wire  [3:0]  axi_wstrb,
  input  wire         axi_wvalid,
  output logic        axi_wready,
  output logic        axi_bvalid,
  output logic [3:0]  axi_bid,
  output logic [1:0]  axi_bresp,
  input  wire         axi_bready
);

  logic [31:0] mem [0:255];  // 1 KiB, wraps on addr[9:2]
  integer      seed = 32'h2c1c;
  logic        ar_hs = 1'b0;
  logic        r_hs = 1'b0;
  logic        aw_hs = 1'b0;
  logic        w_hs = 1'b0;
  logic        b_hs = 1'b0;
  logic [7:0]  rd_index;
  logic [7:0]  wr_index;
  logic        rd_busy;
  logic [1:0]  wr_state;
  int          rd_wait;
  int          wr_wait;

  assign axi_rlast = axi_rvalid;
  assign axi_rid   = 4'd0;
  assign axi_rresp = 2'b00;
  assign axi_bid   = 4'd0;
  assign axi_bresp = 2'b00;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0] ^ 8'h5a, i[7:0], ~i[7:0], i[7:0] + 8'h33};
    end
    axi_arready = 1'b0;
    axi_rvalid  = 1'b0;
    axi_rdata   = 32'd0;
    axi_awready = 1'b0;
    axi_wready  = 1'b0;
    axi_bvalid  = 1'b0;
    rd_busy     = 1'b0;
    wr_state    = 2'd0;
  end

  // handshakes seen at the rising edge, acted on at the falling edge
  always @(posedge clock) begin
    ar_hs <= axi_arvalid && axi_arready;
    r_hs  <= axi_rvalid && axi_rready;
    aw_hs <= axi_awvalid && axi_awready;
    w_hs  <= axi_wvalid && axi_wready;
    b_hs  <= axi_bvalid && axi_bready;
    if (axi_arvalid && axi_arready) rd_index <= axi_araddr[9:2];
    if (axi_awvalid && axi_awready) wr_index <= axi_awaddr[9:2];
    if (axi_wvalid && axi_wready) begin
      for (int b = 0; b < 4; b++) begin
        if (axi_wstrb[b]) mem[wr_index][8*b +: 8] <= axi_wdata[8*b +: 8];
      end
    end
  end

  always @(negedge clock) begin
    if (reset) begin
      axi_arready = 1'b0;
      axi_rvalid  = 1'b0;
      axi_awready = 1'b0;
      axi_wready  = 1'b0;
      axi_bvalid  = 1'b0;
      rd_busy     = 1'b0;
      wr_state    = 2'd0;
    end else begin
      if (r_hs) begin
        axi_rvalid = 1'b0;
        rd_busy    = 1'b0;
      end
      if (ar_hs) begin
        rd_busy = 1'b1;
        rd_wait = 1 + {$random(seed)} % 4;  // R never in the AR cycle's half
      end else if (rd_busy && !axi_rvalid) begin
        rd_wait = rd_wait - 1;
        if (rd_wait == 0) begin
          axi_rvalid = 1'b1;
          axi_rdata  = mem[rd_index];
        end
      end
      axi_arready = !rd_busy && ({$random(seed)} % 4 != 0);

      case (wr_state)
        2'd0: begin
          if (aw_hs) begin
            axi_awready = 1'b0;
            wr_state    = 2'd1;
          end else begin
            axi_awready = ({$random(seed)} % 4 != 0);
          end
        end
        2'd1: begin
          if (w_hs) begin
            axi_wready = 1'b0;
            wr_wait    = 1 + {$random(seed)} % 4;
            wr_state   = 2'd2;
          end else begin
            axi_wready = {$random(seed)} % 2;
          end
        end
        default: begin
          if (b_hs) begin
            axi_bvalid = 1'b0;
            wr_state   = 2'd0;
          end else if (!axi_bvalid) begin
            wr_wait = wr_wait - 1;
            if (wr_wait == 0) axi_bvalid = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb/tb_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_bridge
  import soc_map_pkg::*;
();

  logic        clock;
  logic        reset;
  logic        flush_pipeline;
  logic [31:0] ifu_araddr;
  logic        ifu_arvalid;
  logic        ifu_ready;
  logic        ifu_lock;
  wire         ifu_arready;
  wire  [31:0] ifu_rdata;
  wire         ifu_rvalid;
  logic [31:0] lsu_araddr;
  logic        lsu_arvalid;
  logic [7:0]  lsu_rstrb;
  wire  [31:0] lsu_rdata;
  wire         lsu_rvalid;
  logic [31:0] lsu_awaddr;
  logic        lsu_awvalid;
  logic [31:0] lsu_wdata;
  logic [7:0]  lsu_wstrb;
  logic        lsu_wvalid;
  wire         lsu_wready;

  wire  [1:0]  axi_arburst;
  wire  [2:0]  axi_arsize;
  wire  [7:0]  axi_arlen;
  wire  [3:0]  axi_arid;
  wire  [31:0] axi_araddr;
  wire         axi_arvalid;
  wire         axi_arready;
  wire  [3:0]  axi_rid;
  wire         axi_rlast;
  wire  [31:0] axi_rdata;
  wire  [1:0]  axi_rresp;
  wire         axi_rvalid;
  wire         axi_rready;
  wire  [1:0]  axi_awburst;
  wire  [2:0]  axi_awsize;
  wire  [7:0]  axi_awlen;
  wire  [3:0]  axi_awid;
  wire  [31:0] axi_awaddr;
  wire         axi_awvalid;
  wire         axi_awready;
  wire         axi_wlast;
  wire  [31:0] axi_wdata;
  wire  [3:0]  axi_wstrb;
  wire         axi_wvalid;
  wire         axi_wready;
  wire  [3:0]  axi_bid;
  wire  [1:0]  axi_bresp;
  wire         axi_bvalid;
  wire         axi_bready;

  logic [7:0]  ref_mem [0:1023];
  logic [31:0] exp_fetch;
  logic [31:0] exp_load;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_wstrb;
  logic [2:0]  exp_size;
  logic [2:0]  exp_awsize;
  logic        fetch_open;
  logic        load_open;
  logic        store_open;
  logic        timer_phase;
  logic        timer_first;
  int errors = 0;
  int tx_count = 0;
  int cycles = 0;
  int fetch_issued = 0;
  int fetch_done = 0;
  int load_issued = 0;
  int load_done = 0;
  int store_issued = 0;
  int store_done = 0;

  bus_bridge UUT (
    .clock (clock), .reset (reset), .flush_pipeline (flush_pipeline),
    .ifu_araddr (ifu_araddr), .ifu_arvalid (ifu_arvalid), .ifu_ready (ifu_ready),
    .ifu_lock (ifu_lock), .ifu_arready (ifu_arready), .ifu_rdata (ifu_rdata),
    .ifu_rvalid (ifu_rvalid),
    .lsu_araddr (lsu_araddr), .lsu_arvalid (lsu_arvalid), .lsu_rstrb (lsu_rstrb),
    .lsu_rdata (lsu_rdata), .lsu_rvalid (lsu_rvalid),
    .lsu_awaddr (lsu_awaddr), .lsu_awvalid (lsu_awvalid), .lsu_wdata (lsu_wdata),
    .lsu_wstrb (lsu_wstrb), .lsu_wvalid (lsu_wvalid), .lsu_wready (lsu_wready),
    .axi_arburst (axi_arburst), .axi_arsize (axi_arsize),
    .axi_arlen (axi_arlen), .axi_arid (axi_arid),
    .axi_araddr (axi_araddr), .axi_arvalid (axi_arvalid), .axi_arready (axi_arready),
    .axi_rid (axi_rid), .axi_rlast (axi_rlast), .axi_rdata (axi_rdata),
    .axi_rresp (axi_rresp), .axi_rvalid (axi_rvalid), .axi_rready (axi_rready),
    .axi_awburst (axi_awburst), .axi_awsize (axi_awsize),
    .axi_awlen (axi_awlen), .axi_awid (axi_awid),
    .axi_awaddr (axi_awaddr), .axi_awvalid (axi_awvalid), .axi_awready (axi_awready),
    .axi_wlast (axi_wlast), .axi_wdata (axi_wdata), .axi_wstrb (axi_wstrb),
    .axi_wvalid (axi_wvalid), .axi_wready (axi_wready),
    .axi_bid (axi_bid), .axi_bresp (axi_bresp), .axi_bvalid (axi_bvalid),
    .axi_bready (axi_bready)
  );

  axi_mem_model u_mem (
    .clock (clock), .reset (reset),
    .axi_araddr (axi_araddr), .axi_arvalid (axi_arvalid), .axi_arready (axi_arready),
    .axi_rdata (axi_rdata), .axi_rvalid (axi_rvalid), .axi_rlast (axi_rlast),
    .axi_rid (axi_rid), .axi_rresp (axi_rresp), .axi_rready (axi_rready),
    .axi_awaddr (axi_awaddr), .axi_awvalid (axi_awvalid), .axi_awready (axi_awready),
    .axi_wdata (axi_wdata), .axi_wstrb (axi_wstrb), .axi_wvalid (axi_wvalid),
    .axi_wready (axi_wready), .axi_bvalid (axi_bvalid), .axi_bid (axi_bid),
    .axi_bresp (axi_bresp), .axi_bready (axi_bready)
  );

  always #5 clock = ~clock;

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  task automatic report_event(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [9:0] base;
    base = {addr[9:2], 2'b00};
    return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
  endfunction

  // byte, half, word
  function automatic logic [2:0] expected_size(input logic [3:0] strb);
    case (strb)
      4'h3: return 3'd1;
      4'hf: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  a_fetch_data: assert property (@(posedge clock) disable iff (reset)
    ifu_rvalid |-> ifu_rdata == exp_fetch)
    else report_value("ifu_rdata", $sampled(ifu_rdata), exp_fetch);
  a_fetch_once: assert property (@(posedge clock) disable iff (reset)
    ifu_rvalid |-> fetch_open)
    else report_event("ifu_rvalid without an open fetch");
  a_fetch_size: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && ifu_arready |-> axi_arsize == 3'd2)
    else report_value("axi_arsize", $sampled(axi_arsize), 3'd2);
  a_load_size: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid && !ifu_arready |-> axi_arsize == exp_size)
    else report_value("axi_arsize", $sampled(axi_arsize), exp_size);
  a_arlen: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid |-> axi_arlen == 8'd0)
    else report_value("axi_arlen", $sampled(axi_arlen), 8'd0);
  a_arburst: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid |-> axi_arburst == 2'b00)
    else report_value("axi_arburst", $sampled(axi_arburst), 2'b00);
  a_arid: assert property (@(posedge clock) disable iff (reset)
    axi_arvalid |-> axi_arid == 4'd0)
    else report_value("axi_arid", $sampled(axi_arid), 4'd0);
  a_load_data: assert property (@(posedge clock) disable iff (reset)
    lsu_rvalid && !timer_phase |-> lsu_rdata == exp_load)
    else report_value("lsu_rdata", $sampled(lsu_rdata), exp_load);
  a_load_once: assert property (@(posedge clock) disable iff (reset)
    lsu_rvalid |-> load_open)
    else report_event("lsu_rvalid without an open load");
  a_awsize: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> axi_awsize == exp_awsize)
    else report_value("axi_awsize", $sampled(axi_awsize), exp_awsize);
  a_awlen: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> axi_awlen == 8'd0)
    else report_value("axi_awlen", $sampled(axi_awlen), 8'd0);
  a_awburst: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> axi_awburst == 2'b00)
    else report_value("axi_awburst", $sampled(axi_awburst), 2'b00);
  a_awid: assert property (@(posedge clock) disable iff (reset)
    axi_awvalid |-> axi_awid == 4'd0)
    else report_value("axi_awid", $sampled(axi_awid), 4'd0);
  a_wdata: assert property (@(posedge clock) disable iff (reset)
    axi_wvalid |-> axi_wdata == exp_wdata)
    else report_value("axi_wdata", $sampled(axi_wdata), exp_wdata);
  a_wstrb: assert property (@(posedge clock) disable iff (reset)
    axi_wvalid |-> axi_wstrb == exp_wstrb)
    else report_value("axi_wstrb", $sampled(axi_wstrb), exp_wstrb);
  a_wlast: assert property (@(posedge clock) disable iff (reset)
    axi_wvalid |-> axi_wlast)
    else report_event("axi_wlast low on the single W beat");
  a_store_once: assert property (@(posedge clock) disable iff (reset)
    lsu_wready |-> store_open)
    else report_event("lsu_wready without an open store");
  a_timer_local: assert property (@(posedge clock) disable iff (reset)
    timer_phase |-> !axi_arvalid)
    else report_event("timer load reached the AXI read channel");
  a_timer_latency: assert property (@(posedge clock) disable iff (reset)
    timer_first |=> lsu_rvalid)
    else report_event("no timer response one cycle after the request");
  a_lock: assert property (@(posedge clock) disable iff (reset)
    ifu_lock && ifu_arready && !ifu_arvalid |=> ifu_arready)
    else report_event("load granted while ifu_lock was high");

  always @(posedge clock) begin
    if (!reset) begin
      if (ifu_rvalid) fetch_done++;
      if (lsu_rvalid) load_done++;
      if (lsu_wready) store_done++;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > 40 * tx_count + 100) begin
      $display("Timeout: bus bridge stopped responding after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_level(input string name, input logic got, input logic want);
    assert (got == want) else report_value(name, got, want);
  endtask

  task automatic fetch_word(input logic [31:0] addr);
    @(negedge clock);
    exp_fetch   = ref_word(addr);
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    ifu_ready   = 1'b1;
    fetch_open  = 1'b1;
    fetch_issued++;
    tx_count++;
    do @(posedge clock); while (!(ifu_arready && axi_arready));
    @(negedge clock);
    ifu_arvalid = 1'b0;
    do @(posedge clock); while (!ifu_rvalid);
    fetch_open = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [3:0] strb);
    @(negedge clock);
    exp_load    = ref_word(addr);
    exp_size    = expected_size(strb);
    lsu_araddr  = addr;
    lsu_rstrb   = {4'h0, strb};
    lsu_arvalid = 1'b1;
    load_open   = 1'b1;
    load_issued++;
    tx_count++;
    do @(posedge clock); while (!lsu_rvalid);
    load_open = 1'b0;
    @(negedge clock);
    lsu_arvalid = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    @(negedge clock);
    exp_wdata   = data << (8 * addr[1:0]);
    exp_wstrb   = strb << addr[1:0];
    exp_awsize  = expected_size(strb);
    lsu_awaddr  = addr;
    lsu_wdata   = data;
    lsu_wstrb   = {4'h0, strb};
    lsu_awvalid = 1'b1;
    lsu_wvalid  = 1'b1;
    store_open  = 1'b1;
    store_issued++;
    tx_count++;
    do @(posedge clock); while (!lsu_wready);
    store_open = 1'b0;
    for (int b = 0; b < 4; b++) begin
      if (exp_wstrb[b]) ref_mem[{addr[9:2], 2'b00} + b] = exp_wdata[8*b +: 8];
    end
    @(negedge clock);
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
  endtask

  // bridge must already sit in load grant
  task automatic timer_load(input logic [31:0] addr, output logic [31:0] value);
    @(negedge clock);
    exp_size    = 3'd2;
    lsu_araddr  = addr;
    lsu_rstrb   = 8'h0f;
    lsu_arvalid = 1'b1;
    timer_first = 1'b1;
    load_open   = 1'b1;
    load_issued++;
    tx_count++;
    @(negedge clock);
    timer_first = 1'b0;
    do @(posedge clock); while (!lsu_rvalid);
    value     = lsu_rdata;
    load_open = 1'b0;
    @(negedge clock);
    lsu_arvalid = 1'b0;
  endtask

  task automatic flushed_load(input logic [31:0] addr);
    @(negedge clock);
    exp_size    = 3'd2;
    lsu_araddr  = addr;
    lsu_rstrb   = 8'h0f;
    lsu_arvalid = 1'b1;
    load_open   = 1'b1;
    tx_count++;
    do @(posedge clock); while (!(axi_arvalid && axi_arready));
    @(negedge clock);
    flush_pipeline = 1'b1;  // core cancels the load
    lsu_arvalid    = 1'b0;
    load_open      = 1'b0;
    @(negedge clock);
    flush_pipeline = 1'b0;
    do @(posedge clock); while (!(axi_rvalid && axi_rready));
  endtask

  initial begin
    logic [31:0] lo_a;
    logic [31:0] lo_b;
    logic [31:0] hi_a;
    logic [31:0] hi_b;
    for (int i = 0; i < 256; i++) begin
      {ref_mem[4*i + 3], ref_mem[4*i + 2], ref_mem[4*i + 1], ref_mem[4*i]} =
        {i[7:0] ^ 8'h5a, i[7:0], ~i[7:0], i[7:0] + 8'h33};
    end
    clock = 1'b0;
    reset = 1'b1;
    flush_pipeline = 1'b0;
    ifu_araddr = 32'd0;
    ifu_arvalid = 1'b0;
    ifu_ready = 1'b0;
    ifu_lock = 1'b0;
    lsu_araddr = 32'd0;
    lsu_arvalid = 1'b0;
    lsu_rstrb = 8'd0;
    lsu_awaddr = 32'd0;
    lsu_awvalid = 1'b0;
    lsu_wdata = 32'd0;
    lsu_wstrb = 8'd0;
    lsu_wvalid = 1'b0;
    exp_fetch = 32'd0;
    exp_load = 32'd0;
    exp_wdata = 32'd0;
    exp_wstrb = 4'd0;
    exp_size = 3'd0;
    exp_awsize = 3'd0;
    fetch_open = 1'b0;
    load_open = 1'b0;
    store_open = 1'b0;
    timer_phase = 1'b0;
    timer_first = 1'b0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    check_level("axi_arvalid", axi_arvalid, 1'b0);
    check_level("axi_awvalid", axi_awvalid, 1'b0);
    check_level("axi_wvalid", axi_wvalid, 1'b0);
    check_level("axi_rready", axi_rready, 1'b0);
    check_level("axi_bready", axi_bready, 1'b0);
    check_level("ifu_rvalid", ifu_rvalid, 1'b0);
    check_level("lsu_rvalid", lsu_rvalid, 1'b0);
    check_level("lsu_wready", lsu_wready, 1'b0);
    check_level("ifu_arready", ifu_arready, 1'b1);

    fetch_word(32'h0000_0100);
    fetch_word(32'h0000_0204);
    load_word(32'h0000_0040, 4'h1);
    load_word(32'h0000_0044, 4'h3);
    load_word(32'h0000_0048, 4'hf);
    store_word(32'h0000_0040, 32'h0000_00c3, 4'h1);
    store_word(32'h0000_0045, 32'h0000_00a7, 4'h1);  // lane 1
    store_word(32'h0000_004a, 32'h0000_beef, 4'h3);  // upper half
    store_word(32'h0000_0050, 32'h1234_5678, 4'hf);
    load_word(32'h0000_0040, 4'hf);
    load_word(32'h0000_0044, 4'h1);
    load_word(32'h0000_0048, 4'h3);
    fetch_word(32'h0000_0050);

    load_word(32'h0000_0060, 4'hf);  // leaves the arbiter in load grant
    timer_phase = 1'b1;
    timer_load(clint_addr_lo, lo_a);
    timer_load(clint_addr_hi, hi_a);
    timer_load(clint_addr_lo, lo_b);
    timer_load(clint_addr_hi, hi_b);
    timer_phase = 1'b0;
    assert (lo_b > lo_a) else report_value("timer lo", lo_b, lo_a);
    assert (hi_b >= hi_a) else report_value("timer hi", hi_b, hi_a);

    flushed_load(32'h0000_0064);
    fetch_word(32'h0000_0068);
    @(negedge clock);
    ifu_lock = 1'b1;
    fork
      load_word(32'h0000_006c, 4'hf);
      begin
        repeat (4) @(negedge clock);
        ifu_lock = 1'b0;
      end
    join
    flushed_load(32'h0000_0070);
    load_word(32'h0000_0074, 4'h3);
    store_word(32'h0000_0074, 32'h0000_5a5a, 4'h3);
    load_word(32'h0000_0074, 4'hf);

    repeat (5) @(negedge clock);
    assert (fetch_done == fetch_issued) else report_event("fetch response count is wrong");
    assert (load_done == load_issued) else report_event("load response count is wrong");
    assert (store_done == store_issued) else report_event("store response count is wrong");
    $display("Done: %0d errors, %0d fetches, %0d loads, %0d stores",
             errors, fetch_done, load_done, store_done);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // transfer size, bytes = 2**size
  localparam logic [2:0] size_byte = 3'd0;
  localparam logic [2:0] size_half = 3'd1;
  localparam logic [2:0] size_word = 3'd2;

  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;  // no bursts issued yet

  localparam logic [3:0] bridge_id = 4'd0;

  // read channel phases
  localparam logic [2:0] rd_fetch_idle    = 3'd0;
  localparam logic [2:0] rd_fetch_wait    = 3'd1;
  localparam logic [2:0] rd_fetch_deliver = 3'd2;
  localparam logic [2:0] rd_load_grant    = 3'd3;
  localparam logic [2:0] rd_load_wait     = 3'd4;
  localparam logic [2:0] rd_load_flushed  = 3'd5;

  // write channel phases
  localparam logic [1:0] wr_addr = 2'd0;
  localparam logic [1:0] wr_data = 2'd1;
  localparam logic [1:0] wr_resp = 2'd2;

  // core strobe to AXI size, unknown patterns fall back to a byte
  function automatic logic [2:0] size_from_strb(input logic [3:0] strb);
    logic [2:0] size;
    case (strb)
      4'b0011: size = size_half;
      4'b1111: size = size_word;
      default: size = size_byte;
    endcase
    return size;
  endfunction

endpackage

`default_nettype wire

/* verilog/bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_bridge
  import axi_pkg::*, soc_map_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   flush_pipeline,

  // fetch
  input  wire [xlen-1:0]        ifu_araddr,
  input  wire                   ifu_arvalid,
  input  wire                   ifu_ready,
  input  wire                   ifu_lock,
  output logic                  ifu_arready,
  output logic [xlen-1:0]       ifu_rdata,
  output logic                  ifu_rvalid,

  // load
  input  wire [xlen-1:0]        lsu_araddr,
  input  wire                   lsu_arvalid,
  input  wire [strb_width-1:0]  lsu_rstrb,
  output logic [xlen-1:0]       lsu_rdata,
  output logic                  lsu_rvalid,

  // store
  input  wire [xlen-1:0]        lsu_awaddr,
  input  wire                   lsu_awvalid,
  input  wire [xlen-1:0]        lsu_wdata,
  input  wire [strb_width-1:0]  lsu_wstrb,
  input  wire                   lsu_wvalid,
  output logic                  lsu_wready,

  // AXI4 master
  output logic [1:0]            axi_arburst,
  output logic [2:0]            axi_arsize,
  output logic [7:0]            axi_arlen,
  output logic [3:0]            axi_arid,
  output logic [xlen-1:0]       axi_araddr,
  output logic                  axi_arvalid,
  input  wire                   axi_arready,

  input  wire [3:0]             axi_rid,
  input  wire                   axi_rlast,
  input  wire [xlen-1:0]        axi_rdata,
  input  wire [1:0]             axi_rresp,
  input  wire                   axi_rvalid,
  output logic                  axi_rready,

  output logic [1:0]            axi_awburst,
  output logic [2:0]            axi_awsize,
  output logic [7:0]            axi_awlen,
  output logic [3:0]            axi_awid,
  output logic [xlen-1:0]       axi_awaddr,
  output logic                  axi_awvalid,
  input  wire                   axi_awready,

  output logic                  axi_wlast,
  output logic [xlen-1:0]       axi_wdata,
  output logic [xlen/8-1:0]     axi_wstrb,
  output logic                  axi_wvalid,
  input  wire                   axi_wready,

  input  wire [3:0]             axi_bid,
  input  wire [1:0]             axi_bresp,
  input  wire                   axi_bvalid,
  output logic                  axi_bready
);

  logic            clint_rd;
  logic            clint_hi;
  logic [xlen-1:0] clint_rdata;
  logic            clint_rvalid;

  // single beat transfers, rid/bid and resp codes not checked
  assign axi_arburst = burst_fixed;
  assign axi_arlen   = 8'd0;
  assign axi_arid    = bridge_id;
  assign axi_awburst = burst_fixed;
  assign axi_awlen   = 8'd0;
  assign axi_awid    = bridge_id;

  read_arbiter u_read_arbiter (
    .clock          (clock),
    .reset          (reset),
    .flush_pipeline (flush_pipeline),
    .ifu_araddr     (ifu_araddr),
    .ifu_arvalid    (ifu_arvalid),
    .ifu_ready      (ifu_ready),
    .ifu_lock       (ifu_lock),
    .ifu_arready    (ifu_arready),
    .ifu_rdata      (ifu_rdata),
    .ifu_rvalid     (ifu_rvalid),
    .lsu_araddr     (lsu_araddr),
    .lsu_arvalid    (lsu_arvalid),
    .lsu_rstrb      (lsu_rstrb),
    .lsu_rdata      (lsu_rdata),
    .lsu_rvalid     (lsu_rvalid),
    .axi_araddr     (axi_araddr),
    .axi_arsize     (axi_arsize),
    .axi_arvalid    (axi_arvalid),
    .axi_arready    (axi_arready),
    .axi_rdata      (axi_rdata),
    .axi_rvalid     (axi_rvalid),
    .axi_rready     (axi_rready),
    .clint_rd       (clint_rd),
    .clint_hi       (clint_hi),
    .clint_rdata    (clint_rdata),
    .clint_rvalid   (clint_rvalid)
  );

  store_channel u_store_channel (
    .clock       (clock),
    .reset       (reset),
    .lsu_awaddr  (lsu_awaddr),
    .lsu_awvalid (lsu_awvalid),
    .lsu_wdata   (lsu_wdata),
    .lsu_wstrb   (lsu_wstrb),
    .lsu_wvalid  (lsu_wvalid),
    .lsu_wready  (lsu_wready),
    .axi_awaddr  (axi_awaddr),
    .axi_awsize  (axi_awsize),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb),
    .axi_wvalid  (axi_wvalid),
    .axi_wlast   (axi_wlast),
    .axi_wready  (axi_wready),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready)
  );

  clint_timer u_clint_timer (
    .clock        (clock),
    .reset        (reset),
    .clint_rd     (clint_rd),
    .clint_hi     (clint_hi),
    .clint_rdata  (clint_rdata),
    .clint_rvalid (clint_rvalid)
  );

endmodule

`default_nettype wire

/* verilog/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer
  import soc_map_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  input  wire             clint_rd,
  input  wire             clint_hi,
  output logic [xlen-1:0] clint_rdata,
  output logic            clint_rvalid
);

  mtime_t mtime;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime.value <= 64'd0;
    end else begin
      mtime.value <= mtime.value + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      clint_rvalid <= 1'b0;
    end else begin
      clint_rvalid <= clint_rd;  // one-cycle answer
    end
  end

  // half selected at request time
  always_ff @(posedge clock) begin
    if (clint_rd) begin
      clint_rdata <= clint_hi ? mtime.words.hi : mtime.words.lo;
    end
  end

endmodule

`default_nettype wire

/* verilog/read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_arbiter
  import axi_pkg::*, soc_map_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   flush_pipeline,

  input  wire [xlen-1:0]        ifu_araddr,
  input  wire                   ifu_arvalid,
  input  wire                   ifu_ready,
  input  wire                   ifu_lock,
  output logic                  ifu_arready,
  output logic [xlen-1:0]       ifu_rdata,
  output logic                  ifu_rvalid,

  input  wire [xlen-1:0]        lsu_araddr,
  input  wire                   lsu_arvalid,
  input  wire [strb_width-1:0]  lsu_rstrb,
  output logic [xlen-1:0]       lsu_rdata,
  output logic                  lsu_rvalid,

  output logic [xlen-1:0]       axi_araddr,
  output logic [2:0]            axi_arsize,
  output logic                  axi_arvalid,
  input  wire                   axi_arready,
  input  wire [xlen-1:0]        axi_rdata,
  input  wire                   axi_rvalid,
  output logic                  axi_rready,

  output logic                  clint_rd,
  output logic                  clint_hi,
  input  wire [xlen-1:0]        clint_rdata,
  input  wire                   clint_rvalid
);

  logic [2:0]      state;
  logic            load_clint;  // current load served by the timer
  logic [xlen-1:0] fetch_data;
  logic            clint_hit;
  logic            fetch_req;
  logic            load_axi_req;
  logic            resp_valid;

  assign clint_hit = (lsu_araddr == clint_addr_lo) || (lsu_araddr == clint_addr_hi);
  assign clint_hi  = (lsu_araddr == clint_addr_hi);

  assign fetch_req    = (state == rd_fetch_idle) && ifu_arvalid && ifu_ready;
  assign load_axi_req = (state == rd_load_grant) && lsu_arvalid && !clint_hit;

  // response source of the load in flight
  assign resp_valid = load_clint ? clint_rvalid : axi_rvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= rd_fetch_idle;
      load_clint <= 1'b0;
    end else begin
      case (state)
        rd_fetch_idle: begin
          if (fetch_req) begin
            if (axi_arready) state <= rd_fetch_wait;
          end else if (!ifu_lock && lsu_arvalid) begin
            state <= rd_load_grant;
          end
        end
        rd_fetch_wait: begin
          if (axi_rvalid) state <= rd_fetch_deliver;
        end
        rd_fetch_deliver: state <= rd_fetch_idle;
        rd_load_grant: begin
          if (lsu_arvalid && clint_hit) begin
            load_clint <= 1'b1;
            state      <= flush_pipeline ? rd_load_flushed : rd_load_wait;
          end else if (load_axi_req && axi_arready) begin
            load_clint <= 1'b0;
            state      <= flush_pipeline ? rd_load_flushed : rd_load_wait;
          end else if (!lsu_arvalid && ifu_arvalid) begin
            state <= rd_fetch_idle;  // hand the port back to fetch
          end
        end
        rd_load_wait: begin
          if (resp_valid) begin
            state <= rd_load_grant;
          end else if (flush_pipeline) begin
            state <= rd_load_flushed;
          end
        end
        rd_load_flushed: begin
          if (resp_valid) state <= rd_load_grant;  // beat dropped
        end
        default: state <= rd_fetch_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == rd_fetch_wait && axi_rvalid) fetch_data <= axi_rdata;
  end

  assign ifu_arready = (state == rd_fetch_idle);
  assign ifu_rdata   = fetch_data;
  assign ifu_rvalid  = (state == rd_fetch_deliver);

  assign lsu_rvalid = (state == rd_load_wait) && resp_valid;
  assign lsu_rdata  = load_clint ? clint_rdata : axi_rdata;

  assign clint_rd = (state == rd_load_grant) && lsu_arvalid && clint_hit;

  assign axi_araddr  = (state == rd_load_grant) ? lsu_araddr : ifu_araddr;
  assign axi_arsize  = (state == rd_load_grant) ? size_from_strb(lsu_rstrb[3:0]) : size_word;
  assign axi_arvalid = fetch_req || load_axi_req;

  // flushed loads still drain their R beat
  assign axi_rready = (state == rd_fetch_wait) ||
                      (((state == rd_load_wait) || (state == rd_load_flushed)) && !load_clint);

endmodule

`default_nettype wire

/* verilog/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  localparam int xlen = 32;

  // only the low 4 bits carry meaning on a 32-bit core
  localparam int strb_width = 8;

  // mtime, lo word then hi word
  localparam logic [31:0] clint_addr_lo = 32'h0200_bff8;
  localparam logic [31:0] clint_addr_hi = 32'h0200_bffc;

  // timer count, read whole or per half
  typedef union packed {
    logic [63:0] value;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } words;
  } mtime_t;

endpackage

`default_nettype wire

/* verilog/store_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module store_channel
  import axi_pkg::*, soc_map_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,

  input  wire [xlen-1:0]        lsu_awaddr,
  input  wire                   lsu_awvalid,
  input  wire [xlen-1:0]        lsu_wdata,
  input  wire [strb_width-1:0]  lsu_wstrb,
  input  wire                   lsu_wvalid,
  output logic                  lsu_wready,

  output logic [xlen-1:0]       axi_awaddr,
  output logic [2:0]            axi_awsize,
  output logic                  axi_awvalid,
  input  wire                   axi_awready,

  output logic [xlen-1:0]       axi_wdata,
  output logic [xlen/8-1:0]     axi_wstrb,
  output logic                  axi_wvalid,
  output logic                  axi_wlast,
  input  wire                   axi_wready,

  input  wire                   axi_bvalid,
  output logic                  axi_bready
);

  logic [1:0] state;
  logic       w_done;  // the single W beat has gone out
  logic [1:0] lane;

  assign lane = lsu_awaddr[1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= wr_addr;
      w_done <= 1'b0;
    end else begin
      case (state)
        wr_addr: begin
          if (axi_awvalid && axi_awready) begin
            state  <= wr_data;
            w_done <= 1'b0;
          end
        end
        wr_data: begin
          if (axi_wvalid && axi_wready) begin
            w_done <= 1'b1;
            state  <= wr_resp;
          end
        end
        wr_resp: begin
          if (axi_bvalid) state <= wr_addr;
        end
        default: state <= wr_addr;
      endcase
    end
  end

  assign axi_awaddr  = lsu_awaddr;
  assign axi_awsize  = size_from_strb(lsu_wstrb[3:0]);
  assign axi_awvalid = (state == wr_addr) && lsu_awvalid;

  // move bytes up to their lanes
  assign axi_wdata  = lsu_wdata << {lane, 3'b000};
  assign axi_wstrb  = lsu_wstrb[3:0] << lane;
  assign axi_wvalid = (state == wr_data) && lsu_wvalid && !w_done;
  assign axi_wlast  = axi_wvalid;  // single beat

  assign axi_bready = (state == wr_resp);
  assign lsu_wready = axi_bvalid && axi_bready;

endmodule

`default_nettype wire
